// File: design/ksBusPkg.sv
// KS-10 backplane shared definitions
// Bus word and address types, address flag bit positions
// Cycle kind and halt cause enums, cycle decode function
// Fixed console IO and halt status addresses
`default_nettype none

package ksBusPkg;

   // 36-bit word, bit 0 is the MSB as on the KS-10
   typedef logic [0:35] wordT;

   // Physical or IO address, word bits 18 to 35
   typedef logic [0:17] addrT;

   ////////////////////////////////////////////////////////////
   // Address word flag positions
   ////////////////////////////////////////////////////////////
   localparam int flagRead     = 3;
   localparam int flagWrite    = 5;
   localparam int flagPhysical = 8;
   localparam int flagIo       = 10;

   // Cycle kind seen on the bus
   typedef enum logic [2:0] {
      cycleNone,
      cycleMemRead,
      cycleMemWrite,
      cycleIoRead,
      cycleIoWrite
   } busCycleE;

   // Halt codes as left in memory location 0 by the microcode
   typedef enum logic [11:0] {
      haltStartup         = 12'o0000,
      haltInstr           = 12'o0001,
      haltConsole         = 12'o0002,
      haltIoPageFail      = 12'o0100,
      haltIllegalInt      = 12'o0101,
      haltZeroVector      = 12'o0102,
      haltIllegalDispatch = 12'o1000,
      haltStartupCheck    = 12'o1005,
      haltUnknown         = 12'o7777
   } haltCauseE;

   ////////////////////////////////////////////////////////////
   // Console IO addresses
   ////////////////////////////////////////////////////////////
   localparam addrT vectorAddr      = 18'o200000;
   localparam addrT conHaltCodeAddr = 18'o200001;
   localparam addrT conHaltPcAddr   = 18'o200002;
   localparam addrT conHsbAddr      = 18'o200100;

   // Halt status locations in physical memory
   localparam addrT haltCodeAddr = 18'o000000;
   localparam addrT haltPcAddr   = 18'o000001;
   localparam addrT hsbBase      = 18'o376000;
   localparam int   hsbWords     = 18;

   // Only physical cycles with exactly one of read or write are valid
   function automatic busCycleE decodeCycle(input wordT a);
      busCycleE kind;
      kind = cycleNone;
      if (a[flagPhysical] && (a[flagRead] != a[flagWrite]))
      begin
         if (a[flagIo] && a[flagRead])
            kind = cycleIoRead;
         else if (a[flagIo])
            kind = cycleIoWrite;
         else if (a[flagRead])
            kind = cycleMemRead;
         else
            kind = cycleMemWrite;
      end
      return kind;
   endfunction

endpackage

`default_nettype wire

// File: design/ksConsole.sv
// KS-10 console bus slave
// Answers the execute/start vector IO read with a fixed JRST word
// Snoops halt code, halt PC and halt status block memory writes
// Halt registers readable through console IO addresses
`timescale 1ns/10ps
`default_nettype none

module ksConsole
   import ksBusPkg::*;
#(
   parameter wordT startVector = 36'o254000030600
)
(
   input  wire logic      clk,
   input  wire logic      rst,
   input  wire logic      req,
   input  wire wordT      addr,
   input  wire wordT      wrData,
   output logic           ack,
   output wordT           rdData,
   output logic           haltSeen,
   output haltCauseE      haltCause
);

   busCycleE  cycle;
   addrT      busAddr;
   addrT      memOff;
   addrT      conOff;
   logic      inHsbMem;
   logic      inHsbCon;
   logic      conHit;
   wordT      conNext;

   // Stored halt status
   wordT      haltCode;
   wordT      haltPc;
   wordT      hsbRegs [hsbWords];

   assign cycle   = decodeCycle(addr);
   assign busAddr = addr[18:35];

   // Offsets into the halt status block, memory side and readback side
   assign memOff   = busAddr - hsbBase;
   assign conOff   = busAddr - conHsbAddr;
   assign inHsbMem = (busAddr >= hsbBase) && (memOff < addrT'(hsbWords));
   assign inHsbCon = (busAddr >= conHsbAddr) && (conOff < addrT'(hsbWords));

   // Low 12 bits of the halt code word select the cause
   function automatic haltCauseE mapCause(input logic [11:0] code);
      haltCauseE cause;
      case (code)
         12'o0000 : cause = haltStartup;
         12'o0001 : cause = haltInstr;
         12'o0002 : cause = haltConsole;
         12'o0100 : cause = haltIoPageFail;
         12'o0101 : cause = haltIllegalInt;
         12'o0102 : cause = haltZeroVector;
         12'o1000 : cause = haltIllegalDispatch;
         12'o1005 : cause = haltStartupCheck;
         default  : cause = haltUnknown;
      endcase
      return cause;
   endfunction

   ////////////////////////////////////////////////////////////
   // IO read decode
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      conHit  = 1'b0;
      conNext = '0;
      if (req && (cycle == cycleIoRead))
      begin
         // Start vector read by microcode at power-up
         if (busAddr == vectorAddr)
         begin
            conHit  = 1'b1;
            conNext = startVector;
         end
         else if (busAddr == conHaltCodeAddr)
         begin
            conHit  = 1'b1;
            conNext = haltCode;
         end
         else if (busAddr == conHaltPcAddr)
         begin
            conHit  = 1'b1;
            conNext = haltPc;
         end
         else if (inHsbCon)
         begin
            conHit  = 1'b1;
            conNext = hsbRegs[conOff[13:17]];
         end
      end
   end

   // Response registered one cycle after req
   always_ff @(posedge clk)
   begin
      if (rst)
         ack <= 1'b0;
      else
         ack <= conHit;
   end

   always_ff @(posedge clk)
   begin
      rdData <= conNext;
   end

   ////////////////////////////////////////////////////////////
   // Halt status snoop
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         haltCode  <= '0;
         haltPc    <= '0;
         haltSeen  <= 1'b0;
         haltCause <= haltStartup;
         for (int i = 0; i < hsbWords; i++)
            hsbRegs[i] <= '0;
      end
      else
      begin
         haltSeen <= 1'b0;
         if (req && (cycle == cycleMemWrite))
         begin
            // Halt code write marks the halt itself
            if (busAddr == haltCodeAddr)
            begin
               haltCode  <= wrData;
               haltCause <= mapCause(wrData[24:35]);
               haltSeen  <= 1'b1;
            end
            else if (busAddr == haltPcAddr)
               haltPc <= wrData;
            else if (inHsbMem)
               hsbRegs[memOff[13:17]] <= wrData;
         end
      end
   end

endmodule

`default_nettype wire

// File: design/ksMemory.sv
// KS-10 physical memory bus slave
// Synchronous word array, acknowledges in-range memory cycles
`timescale 1ns/10ps
`default_nettype none

module ksMemory
   import ksBusPkg::*;
#(
   parameter int memAddrWidth = 10
)
(
   input  wire logic clk,
   input  wire logic rst,
   input  wire logic req,
   input  wire wordT addr,
   input  wire wordT wrData,
   output logic      ack,
   output wordT      rdData
);

   localparam int memDepth = 1 << memAddrWidth;

   busCycleE                cycle;
   addrT                    busAddr;
   logic                    inRange;
   logic                    memRd;
   logic                    memWr;
   logic [memAddrWidth-1:0] memIdx;

   // Storage, contents undefined after reset
   wordT mem [memDepth];

   assign cycle   = decodeCycle(addr);
   assign busAddr = addr[18:35];

   // Upper address bits must be zero for a hit
   assign inRange = (busAddr >> memAddrWidth) == '0;
   assign memIdx  = busAddr[18-memAddrWidth +: memAddrWidth];

   assign memRd = req && inRange && (cycle == cycleMemRead);
   assign memWr = req && inRange && (cycle == cycleMemWrite);

   ////////////////////////////////////////////////////////////
   // Acknowledge
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (rst)
         ack <= 1'b0;
      else
         ack <= memRd || memWr;
   end

   // Array write and registered read
   always_ff @(posedge clk)
   begin
      if (memWr)
         mem[memIdx] <= wrData;
      // Write cycles return zero
      if (memRd)
         rdData <= mem[memIdx];
      else
         rdData <= '0;
   end

endmodule

`default_nettype wire

// File: design/ksBusResp.sv
// KS-10 bus response stage
// Tracks the outstanding request and merges slave acknowledges
// Non-existent address flagged when no slave answered
`timescale 1ns/10ps
`default_nettype none

module ksBusResp
   import ksBusPkg::*;
(
   input  wire logic clk,
   input  wire logic rst,
   input  wire logic req,
   input  wire logic conAck,
   input  wire wordT conData,
   input  wire logic memAck,
   input  wire wordT memData,
   output logic      respValid,
   output wordT      respData,
   output logic      respNxm
);

   // Request issued in the previous cycle
   logic pending;
   logic anyAck;

   ////////////////////////////////////////////////////////////
   // Outstanding request
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (rst)
         pending <= 1'b0;
      else
         pending <= req;
   end

   // Slaves answer in the cycle after req, same as pending
   assign anyAck    = conAck || memAck;
   assign respValid = pending;
   assign respNxm   = pending && !anyAck;

   ////////////////////////////////////////////////////////////
   // Data merge
   ////////////////////////////////////////////////////////////
   // Address spaces are disjoint so at most one ack is high
   always_comb
   begin
      if (conAck)
         respData = conData;
      else if (memAck)
         respData = memData;
      else
         respData = '0;
   end

endmodule

`default_nettype wire

// File: design/ksBackplane.sv
// KS-10 backplane top level
// Single request port fanned out to the console and memory slaves
// Response stage merges their answers
`timescale 1ns/10ps
`default_nettype none

module ksBackplane
   import ksBusPkg::*;
#(
   parameter wordT startVector  = 36'o254000030600,
   parameter int   memAddrWidth = 10
)
(
   input  wire logic clk,
   input  wire logic rst,
   input  wire logic req,
   input  wire wordT addr,
   input  wire wordT wrData,
   output logic      respValid,
   output wordT      respData,
   output logic      respNxm,
   output logic      haltSeen,
   output haltCauseE haltCause
);

   // Slave answers
   logic conAck;
   wordT conData;
   logic memAck;
   wordT memData;

   ////////////////////////////////////////////////////////////
   // Bus slaves
   ////////////////////////////////////////////////////////////
   ksConsole #(
      .startVector (startVector)
   ) u_ksConsole (
      .clk         (clk),
      .rst         (rst),
      .req         (req),
      .addr        (addr),
      .wrData      (wrData),
      .ack         (conAck),
      .rdData      (conData),
      .haltSeen    (haltSeen),
      .haltCause   (haltCause)
   );

   ksMemory #(
      .memAddrWidth (memAddrWidth)
   ) u_ksMemory (
      .clk          (clk),
      .rst          (rst),
      .req          (req),
      .addr         (addr),
      .wrData       (wrData),
      .ack          (memAck),
      .rdData       (memData)
   );

   // Response merge
   ksBusResp u_ksBusResp (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .conAck    (conAck),
      .conData   (conData),
      .memAck    (memAck),
      .memData   (memData),
      .respValid (respValid),
      .respData  (respData),
      .respNxm   (respNxm)
   );

endmodule

`default_nettype wire

// File: dv/ksBackplane_props.sv
// Bound checker for the backplane top level
// Response timing and strobe rules as concurrent assertions
`timescale 1ns/10ps
`default_nettype none

module ksBackplaneProps
(
   input wire logic clk,
   input wire logic rst,
   input wire logic req,
   input wire logic respValid,
   input wire logic respNxm,
   input wire logic haltSeen
);

   // Count of assertion failures, read by the testbench at the end
   int failCount = 0;

   // Every request answered exactly one cycle later
   reqGetsResp : assert property (@(posedge clk) disable iff (rst) req |=> respValid)
      else
      begin
         failCount = failCount + 1;
         $error("respValid missing one cycle after req");
      end

   // No response without a request in the previous cycle
   noStrayResp : assert property (@(posedge clk) disable iff (rst) respValid |-> $past(req))
      else
      begin
         failCount = failCount + 1;
         $error("respValid without a preceding req");
      end

   nxmOnlyWithResp : assert property (@(posedge clk) disable iff (rst) respNxm |-> respValid)
      else
      begin
         failCount = failCount + 1;
         $error("respNxm outside a response cycle");
      end

   haltOnlyWithResp : assert property (@(posedge clk) disable iff (rst) haltSeen |-> respValid)
      else
      begin
         failCount = failCount + 1;
         $error("haltSeen outside a response cycle");
      end

endmodule

// Attach to every backplane instance
bind ksBackplane ksBackplaneProps u_props (
   .clk       (clk),
   .rst       (rst),
   .req       (req),
   .respValid (respValid),
   .respNxm   (respNxm),
   .haltSeen  (haltSeen)
);

`default_nettype wire

// File: dv/ksBackplaneTb.sv
// Backplane testbench
// Clock, reset, directed stimulus table, random back-to-back memory phase
// Compare tasks, cycle timeout and final result
`timescale 1ns/10ps
`default_nettype none

module ksBackplaneTb
   import ksBusPkg::*;
;

   localparam int   resetCycles = 4;
   localparam int   randCount   = 16;
   localparam wordT jrstWord    = 36'o254000030600;

   // One directed bus cycle and what it should return
   typedef struct {
      busCycleE  kind;
      addrT      a;
      wordT      wd;
      wordT      expData;
      logic      expNxm;
      logic      expHalt;
      haltCauseE expCause;
   } stimT;

   logic      clk;
   logic      rst;
   logic      req;
   wordT      addr;
   wordT      wrData;
   logic      respValid;
   wordT      respData;
   logic      respNxm;
   logic      haltSeen;
   haltCauseE haltCause;

   stimT        stimTable [$];
   haltCauseE   curCause = haltStartup;
   wordT        model [1024];
   addrT        rndAddr [randCount];
   wordT        rndData [randCount];
   logic [31:0] seed = 32'd27713;
   int          cycleCount = 0;
   int          cycleLimit = 1000;

   ksBackplane #(
      .memAddrWidth (10)
   ) u_ksBackplane (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .addr      (addr),
      .wrData    (wrData),
      .respValid (respValid),
      .respData  (respData),
      .respNxm   (respNxm),
      .haltSeen  (haltSeen),
      .haltCause (haltCause)
   );

   // 4 ns clock
   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Run limit
   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount > cycleLimit)
      begin
         $display("sim failed");
         $fatal(1, "Timeout, no end of test after %0d cycles", cycleCount);
      end
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////
   function automatic logic [31:0] lcgNext(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Build the flag bits for a cycle kind, cycleNone drops the physical flag
   function automatic wordT makeAddr(input busCycleE kind, input addrT a);
      wordT w;
      w = '0;
      w[18:35] = a;
      w[flagPhysical] = (kind != cycleNone);
      w[flagIo]       = (kind == cycleIoRead) || (kind == cycleIoWrite);
      w[flagWrite]    = (kind == cycleMemWrite) || (kind == cycleIoWrite);
      w[flagRead]     = !w[flagWrite];
      return w;
   endfunction

   task automatic checkWord(input string name, input wordT got, input wordT exp);
      if (got !== exp)
      begin
         $display("Error %s: got %h expected %h", name, got, exp);
         $display("sim failed");
         $fatal(1, "Data mismatch on %s", name);
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Error %s: got %h expected %h", name, got, exp);
         $display("sim failed");
         $fatal(1, "Flag mismatch on %s", name);
      end
   endtask

   task automatic checkCause(input string name, input haltCauseE got, input haltCauseE exp);
      if (got !== exp)
      begin
         $display("Error %s: got %h expected %h", name, got, exp);
         $display("sim failed");
         $fatal(1, "Halt cause mismatch on %s", name);
      end
   endtask

   task automatic addEntry(input busCycleE kind, input addrT a, input wordT wd,
                           input wordT expData, input logic expNxm);
      stimT e;
      e.kind     = kind;
      e.a        = a;
      e.wd       = wd;
      e.expData  = expData;
      e.expNxm   = expNxm;
      e.expHalt  = 1'b0;
      e.expCause = curCause;
      stimTable.push_back(e);
   endtask

   // Halt code write to location 0, cause holds from here on
   task automatic addHalt(input wordT code, input haltCauseE cause);
      stimT e;
      curCause   = cause;
      e.kind     = cycleMemWrite;
      e.a        = haltCodeAddr;
      e.wd       = code;
      e.expData  = '0;
      e.expNxm   = 1'b0;
      e.expHalt  = 1'b1;
      e.expCause = cause;
      stimTable.push_back(e);
   endtask

   // Single request, response checked on the next falling edge
   task automatic runEntry(input stimT e);
      @(negedge clk);
      req    = 1'b1;
      addr   = makeAddr(e.kind, e.a);
      wrData = e.wd;
      @(negedge clk);
      req    = 1'b0;
      addr   = '0;
      wrData = '0;
      checkFlag("respValid", respValid, 1'b1);
      checkWord("respData", respData, e.expData);
      checkFlag("respNxm", respNxm, e.expNxm);
      checkFlag("haltSeen", haltSeen, e.expHalt);
      checkCause("haltCause", haltCause, e.expCause);
   endtask

   ////////////////////////////////////////////////////////////
   // Directed table
   ////////////////////////////////////////////////////////////
   task automatic buildTable();
      // Halt registers read zero straight after reset
      addEntry(cycleIoRead, conHaltCodeAddr, '0, '0, 1'b0);
      addEntry(cycleIoRead, conHaltPcAddr, '0, '0, 1'b0);
      addEntry(cycleIoRead, conHsbAddr + 18'd5, '0, '0, 1'b0);
      // Start vector, then IO addresses nobody answers
      addEntry(cycleIoRead, vectorAddr, '0, jrstWord, 1'b0);
      addEntry(cycleIoRead, 18'o200077, '0, '0, 1'b1);
      addEntry(cycleIoWrite, vectorAddr, 36'o1, '0, 1'b1);
      // Memory write and readback, top word of the array too
      addEntry(cycleMemWrite, 18'o000100, 36'o123456701234, '0, 1'b0);
      addEntry(cycleMemRead, 18'o000100, '0, 36'o123456701234, 1'b0);
      addEntry(cycleMemWrite, 18'o001777, 36'o777777777777, '0, 1'b0);
      addEntry(cycleMemRead, 18'o001777, '0, 36'o777777777777, 1'b0);
      // First address past 1K words, and a non-physical cycle
      addEntry(cycleMemRead, 18'o002000, '0, '0, 1'b1);
      addEntry(cycleMemWrite, 18'o002000, 36'o55, '0, 1'b1);
      addEntry(cycleNone, 18'o000100, '0, '0, 1'b1);
      // Halt codes, upper bits ignored, 0777 is not a listed code
      addHalt(36'o000000001000, haltIllegalDispatch);
      addEntry(cycleIoRead, conHaltCodeAddr, '0, 36'o000000001000, 1'b0);
      addHalt(36'o000000000102, haltZeroVector);
      addHalt(36'o123456000001, haltInstr);
      addHalt(36'o000000000777, haltUnknown);
      addEntry(cycleIoRead, conHaltCodeAddr, '0, 36'o000000000777, 1'b0);
      addEntry(cycleMemRead, haltCodeAddr, '0, 36'o000000000777, 1'b0);
      // Halt PC lands in both console and memory
      addEntry(cycleMemWrite, haltPcAddr, 36'o000000012345, '0, 1'b0);
      addEntry(cycleIoRead, conHaltPcAddr, '0, 36'o000000012345, 1'b0);
      addEntry(cycleMemRead, haltPcAddr, '0, 36'o000000012345, 1'b0);
      // Status block sits above 1K so memory does not answer
      addEntry(cycleMemWrite, hsbBase, 36'o111111111111, '0, 1'b1);
      addEntry(cycleMemWrite, hsbBase + 18'o7, 36'o222222222222, '0, 1'b1);
      addEntry(cycleMemWrite, hsbBase + 18'o21, 36'o333333333333, '0, 1'b1);
      addEntry(cycleIoRead, conHsbAddr, '0, 36'o111111111111, 1'b0);
      addEntry(cycleIoRead, conHsbAddr + 18'o7, '0, 36'o222222222222, 1'b0);
      addEntry(cycleIoRead, conHsbAddr + 18'o21, '0, 36'o333333333333, 1'b0);
      addEntry(cycleIoRead, conHsbAddr + 18'o22, '0, '0, 1'b1);
      addEntry(cycleIoRead, conHsbAddr + 18'o5, '0, '0, 1'b0);
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////
   initial
   begin
      logic [31:0] r1;
      int          idx;
      wordT        expData;
      rst    = 1'b1;
      req    = 1'b0;
      addr   = '0;
      wrData = '0;
      buildTable();
      cycleLimit = 2 * stimTable.size() + 2 * randCount + resetCycles + 20;

      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      foreach (stimTable[i])
         runEntry(stimTable[i]);

      // Random writes above the halt words, model tracks last value
      for (int i = 0; i < randCount; i++)
      begin
         seed = lcgNext(seed);
         idx  = 2 + int'(seed[31:16]) % 1022;
         seed = lcgNext(seed);
         r1   = seed;
         seed = lcgNext(seed);
         rndAddr[i] = addrT'(idx);
         rndData[i] = {r1[3:0], seed};
         model[idx] = rndData[i];
      end

      // Back to back: request i issued while response i-1 is checked
      for (int i = 0; i <= 2 * randCount; i++)
      begin
         @(negedge clk);
         if (i > 0)
         begin
            if (i - 1 < randCount)
               expData = '0;
            else
               expData = model[int'(rndAddr[i - 1 - randCount])];
            checkFlag("respValid", respValid, 1'b1);
            checkWord("respData", respData, expData);
            checkFlag("respNxm", respNxm, 1'b0);
         end
         if (i < randCount)
         begin
            req    = 1'b1;
            addr   = makeAddr(cycleMemWrite, rndAddr[i]);
            wrData = rndData[i];
         end
         else if (i < 2 * randCount)
         begin
            req    = 1'b1;
            addr   = makeAddr(cycleMemRead, rndAddr[i - randCount]);
            wrData = '0;
         end
         else
         begin
            req    = 1'b0;
            addr   = '0;
         end
      end

      @(negedge clk);
      if (u_ksBackplane.u_props.failCount == 0)
      begin
         $display("sim passed");
         $finish;
      end
      else
      begin
         $display("sim failed");
         $fatal(1, "Bound assertions reported %0d failures", u_ksBackplane.u_props.failCount);
      end
   end

endmodule

`default_nettype wire

// File: ksBackplane.f
design/ksBusPkg.sv
design/ksConsole.sv
design/ksMemory.sv
design/ksBusResp.sv
design/ksBackplane.sv
dv/ksBackplane_props.sv
dv/ksBackplaneTb.sv
